/* list.f */
rtl/special_pkg.sv
rtl/special_ex1_stage.sv
rtl/special_rslt_calc.sv
rtl/special_expt_gen.sv
rtl/special_retire_merge.sv
rtl/special_unit.sv
test/tb_special_unit.sv

/* rtl/special_ex1_stage.sv */
module special_ex1_stage (
  input  logic                                   ex1_ctrl_clk,
  input  logic                                   cpurst_b,
  input  logic                                   rf_sel,
  input  logic                                   flush,
  input  special_pkg::special_func_e             rf_func,
  input  logic [special_pkg::IID_W-1:0]          rf_iid,
  input  logic [special_pkg::OPCODE_W-1:0]       rf_opcode,
  input  logic [special_pkg::XLEN-1:0]           rf_pc,
  input  logic [special_pkg::XLEN-1:0]           rf_src0,
  input  logic [special_pkg::XLEN-1:0]           rf_src1,
  input  logic [special_pkg::PREG_W-1:0]         rf_dst_preg,
  input  logic                                   rf_expt_vld,
  input  logic [special_pkg::EXPT_VEC_W-1:0]     rf_expt_vec,
  input  logic                                   rf_high_hw_expt,
  output logic                                   ex1_inst_vld,
  output special_pkg::special_func_e             ex1_func,
  output logic [special_pkg::IID_W-1:0]          ex1_iid,
  output logic [special_pkg::OPCODE_W-1:0]       ex1_opcode,
  output logic [special_pkg::XLEN-1:0]           ex1_pc,
  output logic [special_pkg::XLEN-1:0]           ex1_src0,
  output logic [special_pkg::XLEN-1:0]           ex1_src1,
  output logic [special_pkg::PREG_W-1:0]         ex1_dst_preg,
  output logic                                   ex1_expt_vld,
  output logic [special_pkg::EXPT_VEC_W-1:0]     ex1_expt_vec,
  output logic                                   ex1_high_hw_expt
);

  import special_pkg::*;

  // ==============================
  // EX1 instruction valid
  // ==============================
  // Flush wins over a new select
  always_ff @(posedge ex1_ctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex1_inst_vld <= 1'b0;
    else if (flush)
      ex1_inst_vld <= 1'b0;
    else
      ex1_inst_vld <= rf_sel;
  end

  // ==============================
  // EX1 instruction fields
  // ==============================
  // Loaded only on select, held otherwise
  always_ff @(posedge ex1_ctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ex1_func         <= FUNC_NOP;
      ex1_iid          <= '0;
      ex1_opcode       <= '0;
      ex1_pc           <= '0;
      ex1_src0         <= '0;
      ex1_src1         <= '0;
      ex1_dst_preg     <= '0;
      ex1_expt_vld     <= 1'b0;
      ex1_expt_vec     <= '0;
      ex1_high_hw_expt <= 1'b0;
    end
    else if (rf_sel)
    begin
      ex1_func         <= rf_func;
      ex1_iid          <= rf_iid;
      ex1_opcode       <= rf_opcode;
      ex1_pc           <= rf_pc;
      ex1_src0         <= rf_src0;
      ex1_src1         <= rf_src1;
      ex1_dst_preg     <= rf_dst_preg;
      ex1_expt_vld     <= rf_expt_vld;
      ex1_expt_vec     <= rf_expt_vec;
      ex1_high_hw_expt <= rf_high_hw_expt;
    end
  end

endmodule

/* rtl/special_expt_gen.sv */
module special_expt_gen (
  input  special_pkg::special_func_e             ex1_func,
  input  logic [special_pkg::XLEN-1:0]           ex1_src0,
  input  logic [special_pkg::XLEN-1:0]           ex1_src1,
  input  logic                                   ex1_expt_vld,
  input  logic [special_pkg::EXPT_VEC_W-1:0]     ex1_expt_vec,
  output logic                                   expt_hit,
  output logic [special_pkg::EXPT_VEC_W-1:0]     expt_vec,
  output logic                                   immu_hit,
  output logic                                   illegal_hit
);

  import special_pkg::*;

  logic inst_nop;
  logic inst_break;
  logic inst_dbgcall;
  logic inst_syscall;
  logic inst_asrtle;
  logic inst_asrtgt;
  logic src_gt;
  logic asrt_fail;
  logic nop_expt;

  // ==============================
  // Function decode
  // ==============================
  assign inst_nop     = (ex1_func == FUNC_NOP);
  assign inst_break   = (ex1_func == FUNC_BREAK);
  assign inst_dbgcall = (ex1_func == FUNC_DBGCALL);
  assign inst_syscall = (ex1_func == FUNC_SYSCALL);
  assign inst_asrtle  = (ex1_func == FUNC_ASRTLE);
  assign inst_asrtgt  = (ex1_func == FUNC_ASRTGT);

  // ==============================
  // Bound-check asserts
  // ==============================
  // Sources compare as two's complement
  assign src_gt = $signed(ex1_src0) > $signed(ex1_src1);

  assign asrt_fail = (inst_asrtgt && !src_gt)
                  || (inst_asrtle && src_gt);

  // ==============================
  // Exception collection
  // ==============================
  // Decode-stage exception rides on a nop
  assign nop_expt = inst_nop && ex1_expt_vld;

  assign expt_hit = asrt_fail
                 || inst_break
                 || inst_dbgcall
                 || inst_syscall
                 || nop_expt;

  // dbgcall raises the exception but leaves the vector at zero
  always_comb
  begin
    if (asrt_fail)
      expt_vec = EXPT_VEC_ASRT;
    else if (inst_syscall)
      expt_vec = EXPT_VEC_SYSCALL;
    else if (inst_break)
      expt_vec = EXPT_VEC_BREAK;
    else if (nop_expt)
      expt_vec = ex1_expt_vec;
    else
      expt_vec = '0;
  end

  // Classification of the carried vector
  assign immu_hit = nop_expt
                 && (ex1_expt_vec inside {EXPT_VEC_IMMU_A, EXPT_VEC_IMMU_B,
                                          EXPT_VEC_IMMU_C, EXPT_VEC_IMMU_D,
                                          EXPT_VEC_IMMU_E});

  assign illegal_hit = nop_expt && (ex1_expt_vec == EXPT_VEC_ILLEGAL);

endmodule

/* rtl/special_pkg.sv */
package special_pkg;

  // ==============================
  // Datapath and field widths
  // ==============================
  localparam int XLEN       = 64;
  localparam int IID_W      = 7;
  localparam int PREG_W     = 7;
  localparam int DREG_W     = 5;
  localparam int FUNC_W     = 5;
  localparam int EXPT_VEC_W = 5;
  localparam int OPCODE_W   = 32;

  // 20-bit signed immediate position in the opcode
  localparam int SI20_LSB = 5;
  localparam int SI20_MSB = 24;

  // Low bits cleared by pcalau12i
  localparam int PCALAU_ALIGN = 12;

  // ==============================
  // Function opcodes
  // ==============================
  typedef enum logic [FUNC_W-1:0] {
    FUNC_NOP       = 5'd0,
    FUNC_CPUFG     = 5'd2,
    FUNC_RDTIMEL   = 5'd3,
    FUNC_RDTIMEH   = 5'd4,
    FUNC_RDTIMED   = 5'd5,
    FUNC_PCADDI    = 5'd6,
    FUNC_PCALAU12I = 5'd7,
    FUNC_PCADDU12I = 5'd8,
    FUNC_PCADDU18I = 5'd9,
    FUNC_BREAK     = 5'd10,
    FUNC_DBGCALL   = 5'd11,
    FUNC_SYSCALL   = 5'd12,
    FUNC_ASRTLE    = 5'd14,
    FUNC_ASRTGT    = 5'd15
  } special_func_e;

  // ==============================
  // Exception vectors
  // ==============================
  localparam logic [EXPT_VEC_W-1:0] EXPT_VEC_ASRT    = 5'hA;
  localparam logic [EXPT_VEC_W-1:0] EXPT_VEC_SYSCALL = 5'hB;
  localparam logic [EXPT_VEC_W-1:0] EXPT_VEC_BREAK   = 5'hC;
  localparam logic [EXPT_VEC_W-1:0] EXPT_VEC_ILLEGAL = 5'hD;

  // Instruction fetch MMU faults carried in from decode
  localparam logic [EXPT_VEC_W-1:0] EXPT_VEC_IMMU_A = 5'h3;
  localparam logic [EXPT_VEC_W-1:0] EXPT_VEC_IMMU_B = 5'h5;
  localparam logic [EXPT_VEC_W-1:0] EXPT_VEC_IMMU_C = 5'h6;
  localparam logic [EXPT_VEC_W-1:0] EXPT_VEC_IMMU_D = 5'h8;
  localparam logic [EXPT_VEC_W-1:0] EXPT_VEC_IMMU_E = 5'hE;

endpackage

/* rtl/special_retire_merge.sv */
module special_retire_merge (
  input  logic                                   ex1_inst_vld,
  input  logic [special_pkg::OPCODE_W-1:0]       ex1_opcode,
  input  logic [special_pkg::IID_W-1:0]          ex1_iid,
  input  logic [special_pkg::PREG_W-1:0]         ex1_dst_preg,
  input  logic                                   ex1_high_hw_expt,
  input  logic [special_pkg::XLEN-1:0]           rslt_data,
  input  logic                                   rslt_vld,
  input  logic                                   expt_hit,
  input  logic [special_pkg::EXPT_VEC_W-1:0]     expt_vec,
  input  logic                                   immu_hit,
  input  logic                                   illegal_hit,
  output logic                                   inst_vld,
  output logic                                   abnormal,
  output logic                                   expt_vld,
  output logic [special_pkg::EXPT_VEC_W-1:0]     expt_vec_out,
  output logic                                   high_hw_expt,
  output logic                                   immu_expt,
  output logic [special_pkg::OPCODE_W-1:0]       mtval,
  output logic [special_pkg::IID_W-1:0]          iid,
  output logic                                   data_vld,
  output logic [special_pkg::XLEN-1:0]           data,
  output logic [special_pkg::PREG_W-1:0]         preg,
  output logic [special_pkg::DREG_W-1:0]         dreg
);

  import special_pkg::*;

  // ==============================
  // Complete bus
  // ==============================
  assign inst_vld     = ex1_inst_vld;
  assign expt_vld     = ex1_inst_vld && expt_hit;
  assign abnormal     = expt_vld;
  assign expt_vec_out = {EXPT_VEC_W{ex1_inst_vld}} & expt_vec;
  assign high_hw_expt = ex1_inst_vld && ex1_high_hw_expt;
  assign immu_expt    = ex1_inst_vld && immu_hit;
  assign iid          = ex1_iid;

  // Illegal instruction reports the raw opcode
  assign mtval = (ex1_inst_vld && illegal_hit) ? ex1_opcode : '0;

  // ==============================
  // Result bus
  // ==============================
  assign data_vld = ex1_inst_vld && rslt_vld;
  assign data     = rslt_data;
  assign preg     = ex1_dst_preg;
  assign dreg     = ex1_opcode[DREG_W-1:0];

endmodule

/* rtl/special_rslt_calc.sv */
module special_rslt_calc (
  input  special_pkg::special_func_e         ex1_func,
  input  logic [special_pkg::XLEN-1:0]       ex1_pc,
  input  logic [special_pkg::OPCODE_W-1:0]   ex1_opcode,
  input  logic [special_pkg::XLEN-1:0]       timer,
  output logic [special_pkg::XLEN-1:0]       rslt_data,
  output logic                               rslt_vld
);

  import special_pkg::*;

  logic [XLEN-1:0] imm_sext;
  logic [XLEN-1:0] pc_offset;
  logic [XLEN-1:0] pc_sum;
  logic [XLEN-1:0] pc_rslt;
  logic [XLEN-1:0] timer_lo;
  logic [XLEN-1:0] timer_hi;

  // ==============================
  // PC-relative adds
  // ==============================
  // Sign-extend si20 from the opcode
  assign imm_sext = {{(XLEN - SI20_MSB + SI20_LSB - 1){ex1_opcode[SI20_MSB]}},
                     ex1_opcode[SI20_MSB:SI20_LSB]};

  // Immediate scaling per instruction
  always_comb
  begin
    case (ex1_func)
      FUNC_PCADDI:    pc_offset = imm_sext << 2;
      FUNC_PCALAU12I: pc_offset = imm_sext << PCALAU_ALIGN;
      FUNC_PCADDU12I: pc_offset = imm_sext << 12;
      FUNC_PCADDU18I: pc_offset = imm_sext << 18;
      default:        pc_offset = '0;
    endcase
  end

  assign pc_sum = ex1_pc + pc_offset;

  // pcalau12i drops the page offset after the add
  always_comb
  begin
    pc_rslt = pc_sum;
    if (ex1_func == FUNC_PCALAU12I)
      pc_rslt[PCALAU_ALIGN-1:0] = '0;
  end

  // ==============================
  // Timer and config reads
  // ==============================
  // Word reads are zero-extended
  assign timer_lo = XLEN'(timer[XLEN/2-1:0]);
  assign timer_hi = XLEN'(timer[XLEN-1:XLEN/2]);

  // Write-back select
  always_comb
  begin
    rslt_data = '0;
    rslt_vld  = 1'b1;
    case (ex1_func)
      FUNC_PCADDI, FUNC_PCALAU12I, FUNC_PCADDU12I, FUNC_PCADDU18I:
        rslt_data = pc_rslt;
      FUNC_RDTIMEL:
        rslt_data = timer_lo;
      FUNC_RDTIMEH:
        rslt_data = timer_hi;
      FUNC_RDTIMED:
        rslt_data = timer;
      // No config registers yet, reads as zero
      FUNC_CPUFG:
        rslt_data = '0;
      // Asserts write back zero
      FUNC_ASRTLE, FUNC_ASRTGT:
        rslt_data = '0;
      default:
      begin
        rslt_data = '0;
        rslt_vld  = 1'b0;
      end
    endcase
  end

endmodule

/* rtl/special_unit.sv */
module special_unit (
  input  logic                                   ex1_ctrl_clk,
  input  logic                                   cpurst_b,
  input  logic                                   rf_sel,
  input  special_pkg::special_func_e             rf_func,
  input  logic [special_pkg::IID_W-1:0]          rf_iid,
  input  logic [special_pkg::OPCODE_W-1:0]       rf_opcode,
  input  logic [special_pkg::XLEN-1:0]           rf_pc,
  input  logic [special_pkg::XLEN-1:0]           rf_src0,
  input  logic [special_pkg::XLEN-1:0]           rf_src1,
  input  logic [special_pkg::PREG_W-1:0]         rf_dst_preg,
  input  logic                                   rf_expt_vld,
  input  logic [special_pkg::EXPT_VEC_W-1:0]     rf_expt_vec,
  input  logic                                   rf_high_hw_expt,
  input  logic [special_pkg::XLEN-1:0]           timer,
  input  logic                                   flush,
  output logic                                   inst_vld,
  output logic                                   abnormal,
  output logic                                   expt_vld,
  output logic [special_pkg::EXPT_VEC_W-1:0]     expt_vec_out,
  output logic                                   high_hw_expt,
  output logic                                   immu_expt,
  output logic [special_pkg::OPCODE_W-1:0]       mtval,
  output logic [special_pkg::IID_W-1:0]          iid,
  output logic                                   data_vld,
  output logic [special_pkg::XLEN-1:0]           data,
  output logic [special_pkg::PREG_W-1:0]         preg,
  output logic [special_pkg::DREG_W-1:0]         dreg
);

  import special_pkg::*;

  // EX1 stage fields
  logic                  ex1_inst_vld;
  special_func_e         ex1_func;
  logic [IID_W-1:0]      ex1_iid;
  logic [OPCODE_W-1:0]   ex1_opcode;
  logic [XLEN-1:0]       ex1_pc;
  logic [XLEN-1:0]       ex1_src0;
  logic [XLEN-1:0]       ex1_src1;
  logic [PREG_W-1:0]     ex1_dst_preg;
  logic                  ex1_expt_vld;
  logic [EXPT_VEC_W-1:0] ex1_expt_vec;
  logic                  ex1_high_hw_expt;

  // EX1 part results
  logic [XLEN-1:0]       rslt_data;
  logic                  rslt_vld;
  logic                  expt_hit;
  logic [EXPT_VEC_W-1:0] expt_vec;
  logic                  immu_hit;
  logic                  illegal_hit;

  // ==============================
  // RF to EX1 register
  // ==============================
  special_ex1_stage special_ex1_stage_inst (
    .ex1_ctrl_clk     (ex1_ctrl_clk),
    .cpurst_b         (cpurst_b),
    .rf_sel           (rf_sel),
    .flush            (flush),
    .rf_func          (rf_func),
    .rf_iid           (rf_iid),
    .rf_opcode        (rf_opcode),
    .rf_pc            (rf_pc),
    .rf_src0          (rf_src0),
    .rf_src1          (rf_src1),
    .rf_dst_preg      (rf_dst_preg),
    .rf_expt_vld      (rf_expt_vld),
    .rf_expt_vec      (rf_expt_vec),
    .rf_high_hw_expt  (rf_high_hw_expt),
    .ex1_inst_vld     (ex1_inst_vld),
    .ex1_func         (ex1_func),
    .ex1_iid          (ex1_iid),
    .ex1_opcode       (ex1_opcode),
    .ex1_pc           (ex1_pc),
    .ex1_src0         (ex1_src0),
    .ex1_src1         (ex1_src1),
    .ex1_dst_preg     (ex1_dst_preg),
    .ex1_expt_vld     (ex1_expt_vld),
    .ex1_expt_vec     (ex1_expt_vec),
    .ex1_high_hw_expt (ex1_high_hw_expt)
  );

  // ==============================
  // EX1 parts
  // ==============================
  special_rslt_calc special_rslt_calc_inst (
    .ex1_func   (ex1_func),
    .ex1_pc     (ex1_pc),
    .ex1_opcode (ex1_opcode),
    .timer      (timer),
    .rslt_data  (rslt_data),
    .rslt_vld   (rslt_vld)
  );

  special_expt_gen special_expt_gen_inst (
    .ex1_func     (ex1_func),
    .ex1_src0     (ex1_src0),
    .ex1_src1     (ex1_src1),
    .ex1_expt_vld (ex1_expt_vld),
    .ex1_expt_vec (ex1_expt_vec),
    .expt_hit     (expt_hit),
    .expt_vec     (expt_vec),
    .immu_hit     (immu_hit),
    .illegal_hit  (illegal_hit)
  );

  // Complete and result bus drive
  special_retire_merge special_retire_merge_inst (
    .ex1_inst_vld     (ex1_inst_vld),
    .ex1_opcode       (ex1_opcode),
    .ex1_iid          (ex1_iid),
    .ex1_dst_preg     (ex1_dst_preg),
    .ex1_high_hw_expt (ex1_high_hw_expt),
    .rslt_data        (rslt_data),
    .rslt_vld         (rslt_vld),
    .expt_hit         (expt_hit),
    .expt_vec         (expt_vec),
    .immu_hit         (immu_hit),
    .illegal_hit      (illegal_hit),
    .inst_vld         (inst_vld),
    .abnormal         (abnormal),
    .expt_vld         (expt_vld),
    .expt_vec_out     (expt_vec_out),
    .high_hw_expt     (high_hw_expt),
    .immu_expt        (immu_expt),
    .mtval            (mtval),
    .iid              (iid),
    .data_vld         (data_vld),
    .data             (data),
    .preg             (preg),
    .dreg             (dreg)
  );

endmodule

/* test/special_trace.txt */
# gap sel flush func pc opcode src0 src1 timer expt_vld expt_vec high_hw iid preg (hex)
# expected: inst_vld abnormal expt_vld expt_vec immu_expt mtval data_vld data (hex)
0 1 0 06 1000 00000204 0 0 0 0 00 0 00 10 1 0 0 00 0 0 1 1040
0 1 0 06 2000 01ffffe1 0 0 0 0 00 0 01 11 1 0 0 00 0 0 1 1ffc
0 1 0 07 80000abc 01ffffdf 0 0 0 0 00 0 02 12 1 0 0 00 0 0 1 7fffe000
0 1 0 08 4000 002468a2 0 0 0 0 00 0 03 13 1 0 0 00 0 0 1 12349000
0 1 0 08 10000 01000003 0 0 0 0 00 0 04 14 1 0 0 00 0 0 1 ffffffff80010000
0 1 0 09 100 00000025 0 0 0 0 00 0 05 15 1 0 0 00 0 0 1 40100
0 1 0 09 1000000 01ffffe6 0 0 0 0 00 0 06 16 1 0 0 00 0 0 1 fc0000
1 1 0 02 0 0000000a 0 0 123456789abcdef0 0 00 0 07 17 1 0 0 00 0 0 1 0
1 1 0 03 0 0000000a 0 0 123456789abcdef0 0 00 0 08 18 1 0 0 00 0 0 1 9abcdef0
1 1 0 04 0 0000000a 0 0 123456789abcdef0 0 00 0 09 19 1 0 0 00 0 0 1 12345678
1 1 0 05 0 0000000a 0 0 123456789abcdef0 0 00 0 0a 1a 1 0 0 00 0 0 1 123456789abcdef0
0 1 0 0e 0 00000003 ffffffffffffffff 1 0 0 00 0 0b 1b 1 0 0 00 0 0 1 0
0 1 0 0e 0 00000003 7 5 0 0 00 0 0c 1c 1 1 1 0a 0 0 1 0
0 1 0 0f 0 00000004 1 ffffffffffffffff 0 0 00 0 0d 1d 1 0 0 00 0 0 1 0
0 1 0 0f 0 00000004 5 5 0 0 00 0 0e 1e 1 1 1 0a 0 0 1 0
0 1 0 0a 0 00000000 0 0 0 0 00 0 0f 1f 1 1 1 0c 0 0 0 0
0 1 0 0c 0 00000000 0 0 0 0 00 0 10 20 1 1 1 0b 0 0 0 0
0 1 0 0b 0 00000000 0 0 0 0 00 0 11 21 1 1 1 00 0 0 0 0
0 1 0 00 0 00000009 0 0 0 1 03 0 12 22 1 1 1 03 1 0 0 0
0 1 0 00 0 00000009 0 0 0 1 0e 1 13 23 1 1 1 0e 1 0 0 0
0 1 0 00 0 deadbeef 0 0 0 1 0d 0 14 24 1 1 1 0d 0 deadbeef 0 0
0 1 0 00 0 00000009 0 0 0 1 04 0 15 25 1 1 1 04 0 0 0 0
0 1 1 06 3000 00000204 0 0 0 0 00 1 16 26 0 0 0 00 0 0 0 0
0 1 0 00 0 00000008 0 0 0 0 00 0 17 27 1 0 0 00 0 0 0 0

/* test/tb_special_unit.sv */
module tb_special_unit;

  import special_pkg::*;

  localparam int MAX_ROWS = 64;
  localparam int N_COL    = 22;
  // Trace columns, stimulus first and expected values after
  localparam int C_GAP = 0, C_SEL = 1, C_FLUSH = 2, C_FUNC = 3, C_PC = 4, C_OPC = 5,
                 C_SRC0 = 6, C_SRC1 = 7, C_TIMER = 8, C_EVLD = 9, C_EVEC = 10,
                 C_HIGH = 11, C_IID = 12, C_PREG = 13, X_INST = 14, X_ABN = 15,
                 X_EVLD = 16, X_EVEC = 17, X_IMMU = 18, X_MTVAL = 19, X_DVLD = 20,
                 X_DATA = 21;

  logic                  ex1_ctrl_clk = 1'b0;
  logic                  cpurst_b = 1'b0;
  logic                  rf_sel = 1'b0;
  logic                  flush = 1'b0;
  special_func_e         rf_func = FUNC_NOP;
  logic [IID_W-1:0]      rf_iid = '0;
  logic [OPCODE_W-1:0]   rf_opcode = '0;
  logic [XLEN-1:0]       rf_pc = '0, rf_src0 = '0, rf_src1 = '0, timer = '0;
  logic [PREG_W-1:0]     rf_dst_preg = '0;
  logic                  rf_expt_vld = 1'b0, rf_high_hw_expt = 1'b0;
  logic [EXPT_VEC_W-1:0] rf_expt_vec = '0;

  logic                  inst_vld, abnormal, expt_vld, high_hw_expt, immu_expt, data_vld;
  logic [EXPT_VEC_W-1:0] expt_vec_out;
  logic [OPCODE_W-1:0]   mtval;
  logic [IID_W-1:0]      iid;
  logic [XLEN-1:0]       data;
  logic [PREG_W-1:0]     preg;
  logic [DREG_W-1:0]     dreg;

  logic [63:0] trace_rows [0:MAX_ROWS-1][0:N_COL-1];
  int          n_rows = 0;
  int          errors = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  int          chk_row;
  int          check_cyc_q [$];
  int          check_row_q [$];

  special_unit special_unit_inst (.*);

  // ==============================
  // Clock, cycle count, timeout
  // ==============================
  always #10 ex1_ctrl_clk = ~ex1_ctrl_clk;

  always @(posedge ex1_ctrl_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: run still busy after %0d cycles, %0d errors", cycle_cnt, errors);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_row(input int r);
    check_value("inst_vld", inst_vld, trace_rows[r][X_INST]);
    check_value("abnormal", abnormal, trace_rows[r][X_ABN]);
    check_value("expt_vld", expt_vld, trace_rows[r][X_EVLD]);
    check_value("expt_vec_out", expt_vec_out, trace_rows[r][X_EVEC]);
    check_value("immu_expt", immu_expt, trace_rows[r][X_IMMU]);
    check_value("mtval", mtval, trace_rows[r][X_MTVAL]);
    check_value("data_vld", data_vld, trace_rows[r][X_DVLD]);
    check_value("high_hw_expt", high_hw_expt, trace_rows[r][X_INST] & trace_rows[r][C_HIGH]);
    if (trace_rows[r][X_DVLD][0])
      check_value("data", data, trace_rows[r][X_DATA]);
    // Pass-through fields only mean something for a live instruction
    if (trace_rows[r][X_INST][0])
    begin
      check_value("dreg", dreg, trace_rows[r][C_OPC][4:0]);
      check_value("iid", iid, trace_rows[r][C_IID]);
      check_value("preg", preg, trace_rows[r][C_PREG]);
    end
  endtask

  // EX1 empty after an RF cycle with sel low
  task automatic expect_idle_outputs();
    check_value("inst_vld", inst_vld, 0);
    check_value("abnormal", abnormal, 0);
    check_value("expt_vld", expt_vld, 0);
    check_value("expt_vec_out", expt_vec_out, 0);
    check_value("immu_expt", immu_expt, 0);
    check_value("mtval", mtval, 0);
    check_value("data_vld", data_vld, 0);
    check_value("high_hw_expt", high_hw_expt, 0);
  endtask

  // Sample one cycle after the row was driven
  always @(posedge ex1_ctrl_clk)
  begin
    #15;
    if (check_cyc_q.size() > 0 && check_cyc_q[0] == cycle_cnt)
    begin
      check_cyc_q.delete(0);
      chk_row = check_row_q.pop_front();
      if (chk_row < 0)
        expect_idle_outputs();
      else
        check_row(chk_row);
    end
  end

  // ==============================
  // Trace load and drive
  // ==============================
  task automatic load_trace();
    int          fd;
    int          cnt;
    string       line;
    logic [63:0] f [0:N_COL-1];
    fd = $fopen("test/special_trace.txt", "r");
    if (fd != 0)
    begin
      while (!$feof(fd) && n_rows < MAX_ROWS)
      begin
        cnt = $fgets(line, fd);
        if (cnt > 0 && line.getc(0) != "#")
        begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                        f[20], f[21]);
          if (cnt == N_COL)
          begin
            for (int k = 0; k < N_COL; k++)
              trace_rows[n_rows][k] = f[k];
            n_rows++;
          end
          else if (cnt > 0)
          begin
            errors++;
            $display("Trace row %0d has %0d columns instead of %0d", n_rows, cnt, N_COL);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_row(input int r);
    rf_sel          = trace_rows[r][C_SEL][0];
    flush           = trace_rows[r][C_FLUSH][0];
    rf_func         = special_func_e'(trace_rows[r][C_FUNC][FUNC_W-1:0]);
    rf_pc           = trace_rows[r][C_PC];
    rf_opcode       = trace_rows[r][C_OPC][OPCODE_W-1:0];
    rf_src0         = trace_rows[r][C_SRC0];
    rf_src1         = trace_rows[r][C_SRC1];
    timer           = trace_rows[r][C_TIMER];
    rf_expt_vld     = trace_rows[r][C_EVLD][0];
    rf_expt_vec     = trace_rows[r][C_EVEC][EXPT_VEC_W-1:0];
    rf_high_hw_expt = trace_rows[r][C_HIGH][0];
    rf_iid          = trace_rows[r][C_IID][IID_W-1:0];
    rf_dst_preg     = trace_rows[r][C_PREG][PREG_W-1:0];
  endtask

  initial
  begin
    load_trace();
    if (n_rows == 0)
    begin
      $display("No stimulus rows could be read from test/special_trace.txt");
      $display("=== FAIL ===");
      $finish;
    end
    else
    begin
      cycle_limit = 2 * n_rows + 10 + 20;
      repeat (10) @(posedge ex1_ctrl_clk);
      #2;
      cpurst_b = 1'b1;
      #13;
      // Outputs straight out of reset
      check_value("inst_vld", inst_vld, 0);
      check_value("data_vld", data_vld, 0);
      check_value("abnormal", abnormal, 0);
      check_value("expt_vld", expt_vld, 0);
      check_value("immu_expt", immu_expt, 0);
      for (int r = 0; r < n_rows; r++)
      begin
        @(posedge ex1_ctrl_clk);
        #2;
        drive_row(r);
        check_cyc_q.push_back(cycle_cnt + 1);
        check_row_q.push_back(r);
        // Idle cycle keeps the timer steady while EX1 reads it
        if (trace_rows[r][C_GAP][0])
        begin
          @(posedge ex1_ctrl_clk);
          #2;
          rf_sel = 1'b0;
          flush  = 1'b0;
          check_cyc_q.push_back(cycle_cnt + 1);
          check_row_q.push_back(-1);
        end
      end
      @(posedge ex1_ctrl_clk);
      #2;
      rf_sel = 1'b0;
      flush  = 1'b0;
      while (check_row_q.size() > 0)
        #1;
      $display("Run complete: %0d rows, %0d errors", n_rows, errors);
      if (errors == 0)
        $display("=== PASS ===");
      else
        $display("=== FAIL ===");
      $finish;
    end
  end

endmodule
